/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* list.f */
verilog/icache_pkg.sv
verilog/icache_control.sv
verilog/icache_tag_check.sv
verilog/icache_stage_reg.sv
verilog/icache_deliver.sv
verilog/icache_top.sv
sim/icache_checker.sv
sim/icache_tb.sv

/* sim/icache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              mem_read,
  input icache_pkg::addr_t mem_address,
  input logic              mem_resp,
  input logic              pmem_read,
  input logic              pmem_resp,
  input icache_pkg::addr_t pmem_address
);

  import icache_pkg::*;

  // a line read stays posted on the same address until memory answers
  pmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
    else $error("pmem_read dropped or pmem_address moved before pmem_resp");

  // the response belongs to a request that was posted when the stage loaded
  resp_has_read: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp |-> $past(mem_read))
    else $error("mem_resp without a posted mem_read");

  // a line fetch reads the aligned line of the address the core is waiting on
  pmem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pmem_read |-> pmem_address == {mem_address[31:s_offset], {s_offset{1'b0}}})
    else $error("pmem_address is not the aligned line of mem_address");

endmodule

bind icache_top icache_checker protocol_check (
  .clk          (clk),
  .rst_n        (rst_n),
  .mem_read     (mem_read),
  .mem_address  (mem_address),
  .mem_resp     (mem_resp),
  .pmem_read    (pmem_read),
  .pmem_resp    (pmem_resp),
  .pmem_address (pmem_address)
);

`default_nettype wire

/* sim/icache_stim.txt */
// columns: cmd (1 read, 0 idle for one cycle), byte address, miss expected (1 = one line fetch)
// set 0 lines sit 0x100 apart, so the later reads walk the tree pseudo-LRU of one set
0 00000000 0
1 00010004 1
1 00010008 0
1 0001000c 0
1 0001001c 0
1 00010000 0
0 00000000 0
1 00010010 0
1 00020044 1
1 00020058 0
1 00010014 0
0 00000000 0
1 00010100 1
1 00010200 1
1 00010300 1
1 00010018 0
1 00010400 1
1 00010104 0
1 0001030c 0
1 0001001c 0
1 00010208 1
1 00010404 1
1 00010300 0
1 00010100 1
1 0001021c 0
0 00000000 0
1 00020040 0
1 00010000 1

/* sim/icache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int stim_depth = 3 * 64;

  logic  clk;
  logic  rst_n;
  logic  mem_read;
  addr_t mem_address;
  logic  mem_resp;
  word_t mem_rdata;
  logic  pmem_read;
  addr_t pmem_address;
  logic  pmem_resp;
  line_t pmem_rdata;

  logic [31:0] stim [stim_depth];
  int          num_req;
  logic        stim_loaded;
  logic [31:0] lfsr;
  addr_t       req_addr;
  int          fetch_count;
  logic        mem_busy;
  int          mem_wait;
  addr_t       mem_line_addr;

  icache_top #(
    .s_index (3)
  ) dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_read     (mem_read),
    .mem_address  (mem_address),
    .mem_resp     (mem_resp),
    .mem_rdata    (mem_rdata),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp),
    .pmem_rdata   (pmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memory holds each word's own address with the upper half inverted
  function automatic word_t rule_word(addr_t a);
    return {~a[31:16], a[15:2], 2'b00};
  endfunction

  function automatic addr_t line_base(addr_t a);
    return {a[31:s_offset], {s_offset{1'b0}}};
  endfunction

  function automatic line_t rule_line(addr_t base);
    line_t l;
    for (int i = 0; i < 8; i++) begin
      l[32*i +: 32] = rule_word(base + addr_t'(4 * i));
    end
    return l;
  endfunction

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_latency(output int lat);
    lfsr = lfsr_step(lfsr);
    lat  = int'(lfsr[0]);
    lfsr = lfsr_step(lfsr);
    lat  = lat + 2 * int'(lfsr[0]) + 1;
  endtask

  task automatic stop_run(string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(string msg);
    stop_run($sformatf("[ERROR] %0d ns: %s", $time, msg));
  endtask

  // line memory, answers one posted read after 1 to 4 cycles
  task automatic serve_memory();
    int lat;
    pmem_resp = 1'b0;
    if (mem_busy) begin
      if (mem_wait == 0) begin
        pmem_resp  = 1'b1;
        pmem_rdata = rule_line(mem_line_addr);
        mem_busy   = 1'b0;
      end else begin
        mem_wait--;
      end
    end else if (pmem_read) begin
      assert (pmem_address == line_base(req_addr))
        else report_error($sformatf("pmem_address %h, expected %h",
                                    pmem_address, line_base(req_addr)));
      pick_latency(lat);
      mem_line_addr = pmem_address;
      mem_wait      = lat - 1;
      mem_busy      = 1'b1;
      fetch_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
    serve_memory();
  endtask

  task automatic check_quiet();
    assert (mem_resp === 1'b0 && pmem_read === 1'b0)
      else report_error($sformatf("mem_resp %b pmem_read %b with no request open",
                                  mem_resp, pmem_read));
  endtask

  task automatic run_request(logic [31:0] cmd, addr_t addr, logic miss);
    int    cycles;
    word_t expected;
    cycles      = 0;
    expected    = rule_word(addr);
    mem_address = addr;
    if (cmd == 0) begin
      mem_read = 1'b0;
      next_cycle();
      check_quiet();
    end else begin
      mem_read    = 1'b1;
      req_addr    = addr;
      fetch_count = 0;
      do begin
        next_cycle();
        cycles++;
      end while (!mem_resp);
      assert (mem_rdata == expected)
        else report_error($sformatf("read %h returned %h, expected %h",
                                    addr, mem_rdata, expected));
      assert (fetch_count == int'(miss))
        else report_error($sformatf("read %h made %0d line fetches, expected %0d",
                                    addr, fetch_count, miss));
      assert (miss || cycles == 1)
        else report_error($sformatf("hit on %h answered after %0d cycles, expected 1",
                                    addr, cycles));
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    mem_read      = 1'b0;
    mem_address   = '0;
    pmem_resp     = 1'b0;
    pmem_rdata    = '0;
    lfsr          = 32'h877;
    fetch_count   = 0;
    mem_busy      = 1'b0;
    mem_wait      = 0;
    mem_line_addr = '0;
    req_addr      = '0;
    stim_loaded   = 1'b0;
    num_req       = 0;
    for (int i = 0; i < stim_depth; i++) begin
      stim[i] = '1;
    end
    $readmemh("sim/icache_stim.txt", stim);
    while (num_req < stim_depth / 3 && stim[3 * num_req] != '1) begin
      num_req++;
    end
    if (num_req == 0) begin
      stop_run("stimulus file sim/icache_stim.txt holds no requests");
    end
    stim_loaded = 1'b1;

    repeat (10) begin
      next_cycle();
      check_quiet();
    end
    rst_n = 1'b1;

    for (int i = 0; i < num_req; i++) begin
      run_request(stim[3 * i], stim[3 * i + 1], stim[3 * i + 2][0]);
    end

    // after the last answer the cache must stay silent
    mem_read = 1'b0;
    repeat (3) begin
      next_cycle();
      check_quiet();
    end

    $display("sim passed");
    $finish;
  end

  // 20 cycles per request plus room for reset and the trailing idle cycles
  initial begin
    wait (stim_loaded);
    repeat (20 * num_req + 20) @(posedge clk);
    stop_run($sformatf("timeout: the requests did not finish within %0d cycles",
                       20 * num_req + 20));
  end

endmodule

`default_nettype wire

/* verilog/icache_control.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_control (
  input  logic clk,
  input  logic rst_n,
  input  logic mem_read,
  input  logic stage_valid,
  input  logic stage_hit,
  input  logic pmem_resp,
  output logic stage_load,
  output logic replay,
  output logic fill,
  output logic pmem_read
);

  typedef enum logic [1:0] {
    st_lookup,
    st_fetch,
    st_replay
  } state_t;

  state_t state;
  state_t state_next;
  logic   miss;

  // a missing record only matters while the core still waits for it
  assign miss = stage_valid & ~stage_hit & mem_read;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_lookup;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    stage_load = 1'b0;
    replay     = 1'b0;
    fill       = 1'b0;
    pmem_read  = 1'b0;

    unique case (state)
      st_lookup: begin
        // keep the missing record in place so its address can be replayed
        if (miss) begin
          state_next = st_fetch;
        end else begin
          stage_load = 1'b1;
        end
      end

      st_fetch: begin
        pmem_read = 1'b1;
        if (pmem_resp) begin
          fill       = 1'b1;
          state_next = st_replay;
        end
      end

      st_replay: begin
        // the held address is looked up again and now hits the new line
        replay     = 1'b1;
        stage_load = 1'b1;
        state_next = st_lookup;
      end

      default: begin
        state_next = st_lookup;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/icache_deliver.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_deliver (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stage_valid,
  input  icache_pkg::stage_t in,
  output logic               mem_resp,
  output icache_pkg::word_t  mem_rdata
);

  logic served_q;
  logic served_phase_q;
  logic dup;

  // a record left in place keeps its phase, a fresh one from the next cycle flips it
  assign dup = served_q && (in.phase == served_phase_q);

  assign mem_resp  = stage_valid && in.hit && !dup;
  assign mem_rdata = in.line[32 * in.addr[4:2] +: 32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      served_q <= 1'b0;
    end else begin
      served_q <= mem_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_resp) begin
      served_phase_q <= in.phase;
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // line geometry is fixed by the 256-bit memory bus
  localparam int s_offset = 5;
  localparam int num_ways = 4;
  localparam int line_bits = 8 * (2 ** s_offset);

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [line_bits-1:0] line_t;

  // tree pseudo-LRU, bit 0 picks the pair and bits 1 and 2 pick inside a pair
  // a zero bit means the left side is the older one
  typedef logic [2:0] plru_t;

  typedef logic [num_ways-1:0] way_mask_t;

  // phase marks which lookup cycle produced the record
  typedef struct packed {
    addr_t     addr;
    logic      hit;
    way_mask_t way_hit;
    line_t     line;
    logic      phase;
  } stage_t;

endpackage

`default_nettype wire

/* verilog/icache_stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_stage_reg (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load,
  input  logic               request,
  input  icache_pkg::stage_t in,
  output icache_pkg::stage_t out,
  output logic               stage_valid
);

  // an idle cycle still loads, which leaves the stage empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else if (load) begin
      stage_valid <= request;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out <= in;
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_tag_check.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_check #(
  parameter int s_index = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  icache_pkg::addr_t  lookup_address,
  input  logic               fill,
  input  icache_pkg::addr_t  fill_address,
  input  icache_pkg::line_t  pmem_rdata,
  output icache_pkg::addr_t  pmem_address,
  output icache_pkg::stage_t result
);

  import icache_pkg::*;

  localparam int s_tag    = 32 - s_offset - s_index;
  localparam int num_sets = 2 ** s_index;

  logic [num_ways-1:0] valid_q [num_sets];
  logic [s_tag-1:0]    tag_q   [num_ways][num_sets];
  line_t               data_q  [num_ways][num_sets];
  plru_t               plru_q  [num_sets];

  logic [s_index-1:0] lk_index;
  logic [s_tag-1:0]   lk_tag;
  logic [s_index-1:0] f_index;
  logic [s_tag-1:0]   f_tag;

  way_mask_t  way_hit;
  logic [1:0] hit_way;
  logic       hit;
  line_t      hit_line;
  logic [1:0] victim;
  logic       phase_q;

  // the way the tree points at as oldest
  function automatic logic [1:0] plru_victim(plru_t p);
    return p[0] ? {1'b1, p[2]} : {1'b0, p[1]};
  endfunction

  // turn every bit on the path to way w so that it points away from w
  function automatic plru_t plru_touch(plru_t p, logic [1:0] w);
    plru_t n;
    n    = p;
    n[0] = ~w[1];
    if (w[1]) begin
      n[2] = ~w[0];
    end else begin
      n[1] = ~w[0];
    end
    return n;
  endfunction

  assign lk_index = lookup_address[s_offset +: s_index];
  assign lk_tag   = lookup_address[31 -: s_tag];
  assign f_index  = fill_address[s_offset +: s_index];
  assign f_tag    = fill_address[31 -: s_tag];

  assign pmem_address = {fill_address[31:s_offset], {s_offset{1'b0}}};

  always_comb begin
    way_hit  = '0;
    hit_way  = 2'd0;
    hit_line = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (valid_q[lk_index][w] && (tag_q[w][lk_index] == lk_tag)) begin
        way_hit[w] = 1'b1;
        hit_way    = 2'(w);
        hit_line   = data_q[w][lk_index];
      end
    end
  end

  assign hit = |way_hit;

  // an empty way is always taken first, lowest index wins
  always_comb begin
    victim = plru_victim(plru_q[f_index]);
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_q[f_index][w]) begin
        victim = 2'(w);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= 1'b0;
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        plru_q[s]  <= '0;
      end
    end else begin
      phase_q <= ~phase_q;
      if (fill) begin
        valid_q[f_index][victim] <= 1'b1;
        plru_q[f_index]          <= plru_touch(plru_q[f_index], victim);
      end else if (hit) begin
        plru_q[lk_index] <= plru_touch(plru_q[lk_index], hit_way);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[victim][f_index]  <= f_tag;
      data_q[victim][f_index] <= pmem_rdata;
    end
  end

  always_comb begin
    result         = '0;
    result.addr    = lookup_address;
    result.hit     = hit;
    result.way_hit = way_hit;
    result.line    = hit_line;
    result.phase   = phase_q;
  end

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
  parameter int s_index = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_read,
  input  icache_pkg::addr_t mem_address,
  output logic              mem_resp,
  output icache_pkg::word_t mem_rdata,
  output logic              pmem_read,
  output icache_pkg::addr_t pmem_address,
  input  logic              pmem_resp,
  input  icache_pkg::line_t pmem_rdata
);

  import icache_pkg::*;

  addr_t  lookup_address;
  stage_t stage_in;
  stage_t stage_out;
  logic   stage_valid;
  logic   stage_load;
  logic   request;
  logic   replay;
  logic   fill;

  // during replay the held miss address goes back through the lookup
  assign lookup_address = replay ? stage_out.addr : mem_address;
  assign request        = mem_read | replay;

  icache_control control (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_read    (mem_read),
    .stage_valid (stage_valid),
    .stage_hit   (stage_out.hit),
    .pmem_resp   (pmem_resp),
    .stage_load  (stage_load),
    .replay      (replay),
    .fill        (fill),
    .pmem_read   (pmem_read)
  );

  icache_tag_check #(
    .s_index (s_index)
  ) tag_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .lookup_address (lookup_address),
    .fill           (fill),
    .fill_address   (stage_out.addr),
    .pmem_rdata     (pmem_rdata),
    .pmem_address   (pmem_address),
    .result         (stage_in)
  );

  icache_stage_reg stage_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (stage_load),
    .request     (request),
    .in          (stage_in),
    .out         (stage_out),
    .stage_valid (stage_valid)
  );

  icache_deliver deliver (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .in          (stage_out),
    .mem_resp    (mem_resp),
    .mem_rdata   (mem_rdata)
  );

endmodule

`default_nettype wire
